// ==== run_sim.sh ====
#!/bin/sh
# build and run the sram subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sram_sys -f tb.f -o sim_tb > compile.log 2>&1
if [ $? -ne 0 ]; then
  cat compile.log
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
  exit 0
else
  echo "pass line not found in sim.log"
  exit 1
fi

// ==== sram_bank_io.sv ====
`timescale 1ns/1ps
`default_nettype none

// pin stage for one chip
// addr, ce and data out leave on the rising edge,
// we and oe get another half cycle through a falling-edge register
module sram_bank_io #(
  parameter int DATA_WIDTH = sram_pkg::DEFAULT_DATA_WIDTH,
  parameter int ADDR_WIDTH = sram_pkg::DEFAULT_ADDR_WIDTH
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [DATA_WIDTH-1:0] sram_dq_in,

  sram_pad_if.io                pad,

  output logic                  bank_rd_valid,
  output logic [DATA_WIDTH-1:0] bank_rd_data,
  output logic [ADDR_WIDTH-1:0] sram_addr,
  output logic                  sram_ce_n,
  output logic                  sram_we_n,
  output logic                  sram_oe_n,
  output logic [DATA_WIDTH-1:0] sram_dq_out,
  output logic                  sram_dq_oe
);

  logic                  we_n_p1;
  logic                  oe_n_p1;
  logic                  oe_q;
  logic                  oe_qq;
  logic                  rd_start;
  logic [1:0]            rd_tag;
  logic [DATA_WIDTH-1:0] rd_hold;

  // rising-edge pin registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sram_ce_n  <= 1'b1;
      sram_dq_oe <= 1'b0;
      we_n_p1    <= 1'b1;
      oe_n_p1    <= 1'b1;
    end else begin
      sram_ce_n  <= pad.ce_n;
      sram_dq_oe <= pad.wr_en;
      we_n_p1    <= pad.we_n;
      oe_n_p1    <= pad.oe_n;
    end
  end

  always_ff @(posedge clk) begin
    sram_addr   <= pad.addr;
    sram_dq_out <= pad.wr_data;
  end

  // second half of the we/oe delay
  // pulses land half a cycle inside the ce window
  always_ff @(negedge clk) begin
    if (!rst_n) begin
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
    end else begin
      sram_we_n <= we_n_p1;
      sram_oe_n <= oe_n_p1;
    end
  end

  // oe pin back in the rising domain, non-inverted
  // first cycle of a read window starts the capture
  assign rd_start = oe_q && !oe_qq;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      oe_q          <= 1'b0;
      oe_qq         <= 1'b0;
      rd_tag        <= '0;
      bank_rd_valid <= 1'b0;
    end else begin
      oe_q          <= !sram_oe_n;
      oe_qq         <= oe_q;
      rd_tag        <= {rd_tag[0], rd_start};
      bank_rd_valid <= rd_tag[1];
    end
  end

  // sample 1.5 cycles into oe, well before ce goes back high
  // then hold until the tag has walked down the pipe
  always_ff @(posedge clk) begin
    if (rd_start) begin
      rd_hold <= sram_dq_in;
    end
    if (rd_tag[1]) begin
      bank_rd_data <= rd_hold;
    end
  end

  // chip must never see a read and a write strobe at once
  a_oe_we_excl : assert property (
    @(posedge clk) disable iff (!rst_n)
    sram_oe_n || sram_we_n
  );

endmodule

`default_nettype wire

// ==== sram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

// access sequencer
// takes one user strobe at a time, picks the bank from the top address bits
// and shapes that bank's strobes over a fixed OP_CYCLES window
module sram_ctrl #(
  parameter int DATA_WIDTH = sram_pkg::DEFAULT_DATA_WIDTH,
  parameter int ADDR_WIDTH = sram_pkg::DEFAULT_ADDR_WIDTH,
  parameter int NUM_BANKS  = sram_pkg::DEFAULT_NUM_BANKS
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  req_valid,
  input  logic                                  req_wr,
  input  logic [ADDR_WIDTH+$clog2(NUM_BANKS)-1:0] req_addr,
  input  logic [DATA_WIDTH-1:0]                 req_wdata,
  // user read return, watched for the latency check only
  input  logic                                  rd_valid,
  output logic                                  busy,
  sram_pad_if.ctrl                              pad [NUM_BANKS]
);

  localparam int BANK_W   = $clog2(NUM_BANKS);
  localparam int CNT_W    = $clog2(sram_pkg::OP_CYCLES + 1);
  // we_n pulse sits in the middle of the window
  localparam int WE_PHASE = sram_pkg::OP_CYCLES / 2;
  localparam int LAST_PH  = sram_pkg::OP_CYCLES - 1;

  logic                  accept;
  logic                  rd_accept;
  logic [CNT_W-1:0]      phase;
  logic                  op_wr;
  logic [BANK_W-1:0]     op_bank;
  logic [ADDR_WIDTH-1:0] op_addr;
  logic [DATA_WIDTH-1:0] op_wdata;

  // strobe is only legal with busy low
  assign accept    = req_valid && !busy;
  assign rd_accept = accept && !req_wr;

  // window control
  // busy rises on the accepting edge, falls OP_CYCLES edges later
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy  <= 1'b0;
      phase <= '0;
    end else if (accept) begin
      busy  <= 1'b1;
      phase <= '0;
    end else if (busy) begin
      if (phase == CNT_W'(LAST_PH)) begin
        busy <= 1'b0;
      end else begin
        phase <= phase + 1'b1;
      end
    end
  end

  // request latch
  // held for the whole window so addr and data are stable at the pins
  always_ff @(posedge clk) begin
    if (accept) begin
      op_wr              <= req_wr;
      {op_bank, op_addr} <= req_addr;
      op_wdata           <= req_wdata;
    end
  end

  // per-bank strobe shaping
  // only the decoded bank sees any low level
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    logic sel;

    assign sel = busy && (op_bank == BANK_W'(b));

    assign pad[b].addr    = op_addr;
    assign pad[b].wr_data = op_wdata;
    assign pad[b].ce_n    = !sel;
    // reads keep oe low over the full window
    assign pad[b].oe_n    = !(sel && !op_wr);
    // data pins driven for the full write window
    assign pad[b].wr_en   = sel && op_wr;
    // single-cycle we pulse, addr and data settled on both sides
    assign pad[b].we_n    = !(sel && op_wr && (phase == CNT_W'(WE_PHASE)));
  end

  // user must wait for busy low
  a_no_req_busy : assert property (
    @(posedge clk) disable iff (!rst_n)
    busy |-> !req_valid
  );

  // end to end read latency through pad stage and merger
  // rd_valid is set on the RD_LATENCY-th edge and sampled one edge later
  a_rd_latency : assert property (
    @(posedge clk) disable iff (!rst_n)
    $past(rd_accept, sram_pkg::RD_LATENCY) |=> rd_valid
  );

endmodule

`default_nettype wire

// ==== sram_pad_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one bank's command bundle, sequencer to pad stage
// levels are at core timing here, the pad stage adds the pin delays
interface sram_pad_if #(
  parameter int DATA_WIDTH = sram_pkg::DEFAULT_DATA_WIDTH,
  parameter int ADDR_WIDTH = sram_pkg::DEFAULT_ADDR_WIDTH
);

  // chip address, broadcast to all banks
  logic [ADDR_WIDTH-1:0] addr;

  // data pin out-enable, only on a selected write
  logic                  wr_en;
  logic [DATA_WIDTH-1:0] wr_data;

  // active low chip strobes, high when deselected
  logic                  ce_n;
  logic                  we_n;
  logic                  oe_n;

  modport ctrl (
    output addr, wr_en, wr_data, ce_n, we_n, oe_n
  );

  modport io (
    input addr, wr_en, wr_data, ce_n, we_n, oe_n
  );

endinterface

`default_nettype wire

// ==== sram_pkg.sv ====
`default_nettype none

// shared sizes and timing for the sram subsystem
package sram_pkg;

  // one chip, 16-bit word
  localparam int DEFAULT_DATA_WIDTH = 16;

  // one chip, 256 words
  localparam int DEFAULT_ADDR_WIDTH = 8;

  // chips on the board
  localparam int DEFAULT_NUM_BANKS = 4;

  // length of one chip access in the sequencer
  // busy covers exactly this many cycles
  localparam int OP_CYCLES = 3;

  // accepting edge to user rd_valid
  // ctrl 0, pin regs 1, oe falling reg 0.5,
  // capture and tag pipe 3.5, merge reg 1
  localparam int RD_LATENCY = 6;

endpackage

`default_nettype wire

// ==== sram_rd_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

// read return merger
// at most one bank returns per cycle, its word goes out on one port
module sram_rd_merge #(
  parameter int DATA_WIDTH = sram_pkg::DEFAULT_DATA_WIDTH,
  parameter int NUM_BANKS  = sram_pkg::DEFAULT_NUM_BANKS
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [NUM_BANKS-1:0]                bank_rd_valid,
  input  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0] bank_rd_data,
  output logic                                rd_valid,
  output logic [DATA_WIDTH-1:0]               rd_data
);

  logic [DATA_WIDTH-1:0] sel_data;

  // and-or select, valid is one-hot
  always_comb begin
    sel_data = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (bank_rd_valid[b]) begin
        sel_data = sel_data | bank_rd_data[b];
      end
    end
  end

  // single pulse per returned word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= |bank_rd_valid;
    end
  end

  // word holds until the next return
  always_ff @(posedge clk) begin
    if (|bank_rd_valid) begin
      rd_data <= sel_data;
    end
  end

  // one access in flight, so banks never return together
  a_onehot_ret : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(bank_rd_valid)
  );

endmodule

`default_nettype wire

// ==== sram_sys.sv ====
`timescale 1ns/1ps
`default_nettype none

// multi-bank async sram subsystem, top level
// user strobe side and packed per-bank pins
module sram_sys #(
  parameter int DATA_WIDTH = sram_pkg::DEFAULT_DATA_WIDTH,
  parameter int ADDR_WIDTH = sram_pkg::DEFAULT_ADDR_WIDTH,
  parameter int NUM_BANKS  = sram_pkg::DEFAULT_NUM_BANKS
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   req_valid,
  input  logic                                   req_wr,
  input  logic [ADDR_WIDTH+$clog2(NUM_BANKS)-1:0] req_addr,
  input  logic [DATA_WIDTH-1:0]                  req_wdata,
  input  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0]   sram_dq_in,
  output logic                                   busy,
  output logic                                   rd_valid,
  output logic [DATA_WIDTH-1:0]                  rd_data,
  output logic [NUM_BANKS-1:0][ADDR_WIDTH-1:0]   sram_addr,
  output logic [NUM_BANKS-1:0]                   sram_ce_n,
  output logic [NUM_BANKS-1:0]                   sram_we_n,
  output logic [NUM_BANKS-1:0]                   sram_oe_n,
  output logic [NUM_BANKS-1:0][DATA_WIDTH-1:0]   sram_dq_out,
  output logic [NUM_BANKS-1:0]                   sram_dq_oe
);

  logic [NUM_BANKS-1:0]                 bank_rd_valid;
  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0] bank_rd_data;

  // one command bundle per chip
  sram_pad_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) pad_if [NUM_BANKS] ();

  sram_ctrl #(
    .DATA_WIDTH(DATA_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH),
    .NUM_BANKS (NUM_BANKS)
  ) i_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_valid(req_valid),
    .req_wr   (req_wr),
    .req_addr (req_addr),
    .req_wdata(req_wdata),
    .rd_valid (rd_valid),
    .busy     (busy),
    .pad      (pad_if)
  );

  // identical pin stage per chip
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_io
    sram_bank_io #(
      .DATA_WIDTH(DATA_WIDTH),
      .ADDR_WIDTH(ADDR_WIDTH)
    ) i_bank_io (
      .clk          (clk),
      .rst_n        (rst_n),
      .sram_dq_in   (sram_dq_in[b]),
      .pad          (pad_if[b]),
      .bank_rd_valid(bank_rd_valid[b]),
      .bank_rd_data (bank_rd_data[b]),
      .sram_addr    (sram_addr[b]),
      .sram_ce_n    (sram_ce_n[b]),
      .sram_we_n    (sram_we_n[b]),
      .sram_oe_n    (sram_oe_n[b]),
      .sram_dq_out  (sram_dq_out[b]),
      .sram_dq_oe   (sram_dq_oe[b])
    );
  end

  sram_rd_merge #(
    .DATA_WIDTH(DATA_WIDTH),
    .NUM_BANKS (NUM_BANKS)
  ) i_rd_merge (
    .clk          (clk),
    .rst_n        (rst_n),
    .bank_rd_valid(bank_rd_valid),
    .bank_rd_data (bank_rd_data),
    .rd_valid     (rd_valid),
    .rd_data      (rd_data)
  );

endmodule

`default_nettype wire

// ==== sram_tb_chip.sv ====
`timescale 1ns/1ps
`default_nettype none

// behavioural async sram chip for simulation
// resolves the split data pins of one bank
module sram_tb_chip #(
  parameter int DATA_WIDTH = sram_pkg::DEFAULT_DATA_WIDTH,
  parameter int ADDR_WIDTH = sram_pkg::DEFAULT_ADDR_WIDTH
) (
  input  wire logic [ADDR_WIDTH-1:0] addr,
  input  wire logic                  ce_n,
  input  wire logic                  we_n,
  input  wire logic                  oe_n,
  input  wire logic [DATA_WIDTH-1:0] dq_out,
  input  wire logic                  dq_oe,
  output logic      [DATA_WIDTH-1:0] dq_in
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  // power-up contents, every word zero
  initial begin
    for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
      mem[i] = '0;
    end
  end

  // chip drives the bus only while selected and output enabled
  // undriven bus reads back as zero
  assign dq_in = (!ce_n && !oe_n) ? mem[addr] : '0;

  // write lands on the trailing edge of we
  // only a driven bus is stored
  always @(posedge we_n) begin
    if (!ce_n && dq_oe) begin
      mem[addr] <= dq_out;
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
sram_pkg.sv
sram_pad_if.sv
sram_ctrl.sv
sram_bank_io.sv
sram_rd_merge.sv
sram_sys.sv
sram_tb_chip.sv
tb_sram_sys.sv

// ==== tb_sram_sys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sram_sys;

  localparam int DW        = sram_pkg::DEFAULT_DATA_WIDTH;
  localparam int AW        = sram_pkg::DEFAULT_ADDR_WIDTH;
  localparam int NB        = sram_pkg::DEFAULT_NUM_BANKS;
  localparam int BW        = $clog2(NB);
  localparam int UAW       = AW + BW;
  localparam int RST_CYC   = 16;
  localparam int N_RANDOM  = 2000;
  localparam int N_OPS     = 2 * NB + N_RANDOM;
  // every op costs OP_CYCLES+1 cycles
  // idle gaps of up to 3 cycles hide under busy
  localparam int TIMEOUT   = N_OPS * (sram_pkg::OP_CYCLES + 1)
                             + sram_pkg::RD_LATENCY + RST_CYC + 100;

  logic                  clk;
  logic                  rst_n;
  logic                  req_valid;
  logic                  req_wr;
  logic [UAW-1:0]        req_addr;
  logic [DW-1:0]         req_wdata;
  logic                  busy;
  logic                  rd_valid;
  logic [DW-1:0]         rd_data;
  logic [NB-1:0][AW-1:0] sram_addr;
  logic [NB-1:0]         sram_ce_n;
  logic [NB-1:0]         sram_we_n;
  logic [NB-1:0]         sram_oe_n;
  logic [NB-1:0][DW-1:0] sram_dq_out;
  logic [NB-1:0]         sram_dq_oe;
  wire  [NB-1:0][DW-1:0] sram_dq_in;

  // reference memory over the full user address
  logic [DW-1:0] model [int];
  // accepted ops keyed by accepting cycle
  int            op_bank [int];
  logic          op_wr [int];
  logic [AW-1:0] op_addr [int];
  logic [DW-1:0] op_data [int];
  // pending reads in issue order
  logic [DW-1:0] exp_data [$];
  int            exp_cycle [$];

  int            cycle = 0;
  logic          checking = 1'b0;
  logic [31:0]   rng = 32'ha123a369;

  sram_sys i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_wr     (req_wr),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .sram_dq_in (sram_dq_in),
    .busy       (busy),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .sram_addr  (sram_addr),
    .sram_ce_n  (sram_ce_n),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .sram_dq_out(sram_dq_out),
    .sram_dq_oe (sram_dq_oe)
  );

  // one chip per bank on its pin slice
  for (genvar b = 0; b < NB; b++) begin : g_chip
    sram_tb_chip #(.DATA_WIDTH(DW), .ADDR_WIDTH(AW)) i_chip (
      .addr  (sram_addr[b]),
      .ce_n  (sram_ce_n[b]),
      .we_n  (sram_we_n[b]),
      .oe_n  (sram_oe_n[b]),
      .dq_out(sram_dq_out[b]),
      .dq_oe (sram_dq_oe[b]),
      .dq_in (sram_dq_in[b])
    );
  end

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_random();
    rng = xorshift32(rng);
    return rng;
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s = 0x%0h, expected 0x%0h (cycle %0d)",
               name, actual, expected, cycle);
      $display("STATUS: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // pins of the op accepted at A are active after edges A+1 .. A+OP_CYCLES
  task automatic check_pins(input int c);
    logic [NB-1:0] ce_exp;
    logic [NB-1:0] oe_exp;
    int            a;
    ce_exp = {NB{1'b1}};
    oe_exp = '0;
    for (int k = 1; k <= sram_pkg::OP_CYCLES; k++) begin
      a = c - k;
      if (op_bank.exists(a)) begin
        ce_exp[op_bank[a]] = 1'b0;
        oe_exp[op_bank[a]] = op_wr[a];
        // chip address and write word held on the selected pins
        expect_eq("sram_addr", 32'(sram_addr[op_bank[a]]), 32'(op_addr[a]));
        if (op_wr[a]) begin
          expect_eq("sram_dq_out", 32'(sram_dq_out[op_bank[a]]), 32'(op_data[a]));
        end
      end
    end
    expect_eq("sram_ce_n", 32'(sram_ce_n), 32'(ce_exp));
    expect_eq("sram_dq_oe", 32'(sram_dq_oe), 32'(oe_exp));
    expect_eq("sram_we_n | sram_oe_n", 32'(sram_we_n | sram_oe_n), 32'({NB{1'b1}}));
  endtask

  task automatic check_user_side(input int c);
    logic busy_exp;
    logic rv_exp;
    // busy from the accepting edge for OP_CYCLES cycles
    busy_exp = 1'b0;
    for (int k = 0; k < sram_pkg::OP_CYCLES; k++) begin
      if (op_bank.exists(c - k)) begin
        busy_exp = 1'b1;
      end
    end
    expect_eq("busy", 32'(busy), 32'(busy_exp));
    rv_exp = (exp_cycle.size() != 0) && (exp_cycle[0] + sram_pkg::RD_LATENCY == c);
    expect_eq("rd_valid", 32'(rd_valid), 32'(rv_exp));
    if (rv_exp) begin
      expect_eq("rd_data", 32'(rd_data), 32'(exp_data[0]));
      void'(exp_data.pop_front());
      void'(exp_cycle.pop_front());
    end
  endtask

  // cycle count, timeout, then samples after the rising and the falling edge
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle > TIMEOUT) begin
      $display("run stopped: stimulus not finished after %0d cycles", TIMEOUT);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
    #2;
    if (checking) begin
      check_pins(cycle);
      check_user_side(cycle);
    end
    #5;
    if (checking) begin
      check_pins(cycle);
    end
  end

  // called 1 ns after an edge; waits for busy low, then one strobe
  task automatic issue(input logic wr, input logic [UAW-1:0] addr, input logic [DW-1:0] data);
    int            acc;
    logic [DW-1:0] rd_exp;
    while (busy) begin
      @(posedge clk);
      #1;
    end
    acc           = cycle + 1;
    req_valid     = 1'b1;
    req_wr        = wr;
    req_addr      = addr;
    req_wdata     = data;
    op_wr[acc]    = wr;
    op_bank[acc]  = int'(addr[UAW-1 -: BW]);
    op_addr[acc]  = addr[AW-1:0];
    op_data[acc]  = data;
    if (wr) begin
      model[int'(addr)] = data;
    end else begin
      // never written words read back as the chip's reset zero
      rd_exp = model.exists(int'(addr)) ? model[int'(addr)] : '0;
      exp_data.push_back(rd_exp);
      exp_cycle.push_back(acc);
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  initial begin
    logic [31:0]    r;
    logic [31:0]    d;
    logic [UAW-1:0] addr;
    logic [AW-1:0]  chip_addr;
    int             gap;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_wr    = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    repeat (RST_CYC) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    // idle state before any request
    expect_eq("busy", 32'(busy), 32'h0);
    expect_eq("rd_valid", 32'(rd_valid), 32'h0);
    expect_eq("sram_ce_n", 32'(sram_ce_n), 32'({NB{1'b1}}));
    expect_eq("sram_we_n", 32'(sram_we_n), 32'({NB{1'b1}}));
    expect_eq("sram_oe_n", 32'(sram_oe_n), 32'({NB{1'b1}}));
    expect_eq("sram_dq_oe", 32'(sram_dq_oe), 32'h0);
    checking = 1'b1;

    // same chip address in every bank, distinct data, then read all back
    r         = next_random();
    chip_addr = r[AW-1:0];
    for (int b = 0; b < NB; b++) begin
      d = next_random();
      issue(1'b1, {BW'(b), chip_addr}, d[DW-1:0]);
    end
    for (int b = 0; b < NB; b++) begin
      issue(1'b0, {BW'(b), chip_addr}, '0);
    end

    // random mix with idle gaps
    for (int i = 0; i < N_RANDOM; i++) begin
      r    = next_random();
      d    = next_random();
      gap  = int'(r[31:30]);
      addr = r[UAW:1];
      // half the traffic crowded onto a few words per bank
      if (r[20]) begin
        addr[AW-1:3] = '0;
      end
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      issue(r[0], addr, d[DW-1:0]);
    end

    // drain outstanding reads
    while (exp_data.size() != 0) begin
      @(posedge clk);
      #1;
    end
    repeat (4) @(posedge clk);
    #1;
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire
